/* build.f */
+incdir+include
hw/corr_pkg.sv
hw/rmw_address_unit.sv
hw/bank_control.sv
hw/correlator_lane.sv
hw/vis_buffer.sv
hw/correlator_block.sv
tb/correlator_block_tb.sv

/* hw/bank_control.sv */
`include "corr_params.svh"

module bank_control
   import corr_pkg::*;
(
   input  logic                   clk_x,
   input  logic                   rst,
   input  logic                   sw_i,      // bank switch pulse
   input  logic                   en_i,      // registered enable
   input  logic                   rd_wrap_i,
   input  logic                   wr_wrap_i,
   output logic                   clear_o,   // lanes add to zero
   output logic [`CORR_BBITS-1:0] bank_o
);

   bank_state_e state_q;
   logic        pend_q;        // switch seen during a clear pass
   logic        bump_q;        // bank step waits for the old last write
   logic        en_d1, en_d2;  // writes trail reads by two cycles
   logic        drained;

   // No reads running and no writes left in flight
   assign drained = !en_i && !en_d1 && !en_d2;

   // Reset pass clears too, memory has no reset
   assign clear_o = (state_q == IDLE) || (state_q == CLEAR_PASS);

   always_ff @(posedge clk_x) begin
      if (rst) begin
         state_q <= IDLE;
         pend_q  <= 1'b0;
         bump_q  <= 1'b0;
         bank_o  <= '0;
         en_d1   <= 1'b0;
         en_d2   <= 1'b0;
      end else begin
         en_d1 <= en_i;
         en_d2 <= en_d1;

         // Old bank's last row is written, step the bank
         if (bump_q && wr_wrap_i) begin
            bump_q <= 1'b0;
            bank_o <= bank_o + 1'b1;
         end

         case (state_q)
            IDLE: begin
               if (rd_wrap_i)
                  state_q <= RUN;
            end

            RUN: begin
               if (sw_i)
                  state_q <= SWAP_PEND;
            end

            // ----------------------------------------------------
            // Further sw_i pulses are absorbed here
            // ----------------------------------------------------
            SWAP_PEND: begin
               if (rd_wrap_i) begin
                  state_q <= CLEAR_PASS; // next capture starts new bank
                  bump_q  <= 1'b1;
               end else if (drained) begin
                  state_q <= CLEAR_PASS; // paused, nothing in flight
                  bank_o  <= bank_o + 1'b1;
               end
            end

            CLEAR_PASS: begin
               if (sw_i)
                  pend_q <= 1'b1;
               if (rd_wrap_i) begin
                  state_q <= (pend_q || sw_i) ? SWAP_PEND : RUN;
                  pend_q  <= 1'b0;
               end
            end

            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

/* hw/corr_pkg.sv */
`include "corr_params.svh"

package corr_pkg;

   // Antenna index width
   localparam int CORR_PW = $clog2(`CORR_NANT);

   // One visibility, Re and Im running sums
   typedef struct packed {
      logic signed [`CORR_ACCUM-1:0] re;
      logic signed [`CORR_ACCUM-1:0] im;
   } vis_t;

   // Read-only bus request
   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic [`CORR_ABITS-1:0] adr;
   } bus_req_t;

   // Bank switch sequencing
   typedef enum logic [1:0] {
      IDLE,       // first pass after reset, memory is garbage
      RUN,
      SWAP_PEND,  // switch seen, waiting for next capture
      CLEAR_PASS  // first pass of the new bank
   } bank_state_e;

   // Pair index -> antennas {a, b}, a < b, lexicographic order
   function automatic logic [2*CORR_PW-1:0] corr_pair(input int unsigned idx);
      int unsigned n;
      logic [2*CORR_PW-1:0] r;
      n = 0;
      r = '0;
      for (int a = 0; a < `CORR_NANT - 1; a++) begin
         for (int b = a + 1; b < `CORR_NANT; b++) begin
            if (n == idx)
               r = {a[CORR_PW-1:0], b[CORR_PW-1:0]};
            n++;
         end
      end
      return r;
   endfunction

endpackage

/* hw/correlator_block.sv */
`include "corr_params.svh"

module correlator_block
   import corr_pkg::*;
(
   input  logic                   clk_x,
   input  logic                   rst,

   // Read-only bus
   input  logic                   cyc_i,
   input  logic                   stb_i,
   input  logic [`CORR_ABITS-1:0] adr_i,
   output logic                   ack_o,
   output logic [`CORR_ACCUM-1:0] dat_o,

   // Antenna samples and control
   input  logic                   sw_i,  // bank switch pulse
   input  logic                   en_i,  // level, samples valid
   input  logic [`CORR_NANT-1:0]  re_i,
   input  logic [`CORR_NANT-1:0]  im_i,

   output logic [`CORR_BBITS-1:0] bank_o
);

   // ------------------------------------------------------------
   // Input registers
   // ------------------------------------------------------------
   logic                  en_q, sw_q;
   logic [`CORR_NANT-1:0] re_q, im_q;
   logic                  capture;

   logic [`CORR_TBITS-1:0] rd_adr, wr_adr;
   logic                   rd_wrap, wr_wrap;
   logic                   clear;

   // Slot 0 of the sample cycle: start of enable, or end of a pass
   assign capture = en_i && (!en_q || rd_wrap);

   always_ff @(posedge clk_x) begin
      if (rst) begin
         en_q <= 1'b0;
         sw_q <= 1'b0;
      end else begin
         en_q <= en_i;
         sw_q <= sw_i;
      end
   end

   // Sample held for all four slots
   always_ff @(posedge clk_x) begin
      if (capture) begin
         re_q <= re_i;
         im_q <= im_i;
      end
   end

   // ------------------------------------------------------------
   // Slot addresses and bank sequencing
   // ------------------------------------------------------------
   rmw_address_unit rmw_i (
      .clk_x     (clk_x),
      .rst       (rst),
      .ce_i      (en_q),
      .rd_adr_o  (rd_adr),
      .wr_adr_o  (wr_adr),
      .rd_wrap_o (rd_wrap),
      .wr_wrap_o (wr_wrap)
   );

   bank_control bank_i (
      .clk_x     (clk_x),
      .rst       (rst),
      .sw_i      (sw_q),
      .en_i      (en_q),
      .rd_wrap_i (rd_wrap),
      .wr_wrap_i (wr_wrap),
      .clear_o   (clear),
      .bank_o    (bank_o)
   );

   // ------------------------------------------------------------
   // Correlator lanes
   // ------------------------------------------------------------
   logic [`CORR_LANES-1:0] vld;
   vis_t [`CORR_LANES-1:0] vis;

   for (genvar l = 0; l < `CORR_LANES; l++) begin : g_lane
      correlator_lane #(.LANE(l)) lane_i (
         .clk_x    (clk_x),
         .rst      (rst),
         .en_i     (en_q),
         .clear_i  (clear),
         .re_i     (re_q),
         .im_i     (im_q),
         .rd_adr_i (rd_adr),
         .wr_adr_i (wr_adr),
         .vld_o    (vld[l]),
         .vis_o    (vis[l])
      );
   end

   // ------------------------------------------------------------
   // Bus, two-stage acknowledge
   // ------------------------------------------------------------
   logic     ack_p;   // row read in progress
   bus_req_t req;

   always_comb begin
      req.cyc = cyc_i;
      req.stb = stb_i && !ack_p && !ack_o; // drop while one is pending
      req.adr = adr_i;
   end

   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack_p <= 1'b0;
         ack_o <= 1'b0;
      end else begin
         ack_p <= req.cyc && req.stb;
         ack_o <= ack_p; // single-cycle pulse
      end
   end

   vis_buffer vis_buf_i (
      .clk_x    (clk_x),
      .we_i     (vld[0]),            // lanes run in lockstep
      .wr_adr_i ({bank_o, wr_adr}),
      .vis_i    (vis),
      .req_i    (req),
      .dat_o    (dat_o)
   );

endmodule

/* hw/correlator_lane.sv */
`include "corr_params.svh"

module correlator_lane
   import corr_pkg::*;
#(
   parameter int LANE = 0 // 0 to 3
) (
   input  logic                   clk_x,
   input  logic                   rst,
   input  logic                   en_i,
   input  logic                   clear_i,
   input  logic [`CORR_NANT-1:0]  re_i,
   input  logic [`CORR_NANT-1:0]  im_i,
   input  logic [`CORR_TBITS-1:0] rd_adr_i,
   input  logic [`CORR_TBITS-1:0] wr_adr_i,
   output logic                   vld_o,
   output vis_t                   vis_o
);

   // Sign bit -> +1 / -1
   function automatic logic signed [2:0] pm1(input logic x);
      return x ? 3'sd1 : -3'sd1;
   endfunction

   // Running sums, one per slot
   vis_t acc_mem [`CORR_TRATE];

   logic [2*CORR_PW-1:0] pair;
   logic [CORR_PW-1:0]   ant_a, ant_b;
   logic                 ra, ia, rb, ib;
   logic signed [2:0]    prod_re, prod_im;

   // Pipeline registers
   vis_t              acc_q;     // stage 1 read data
   logic signed [2:0] p_re_q, p_im_q;
   logic              clr_q;
   logic              v1_q, v2_q;
   vis_t              base;
   vis_t              sum_q;     // stage 2 result

   // ------------------------------------------------------------
   // Pair lookup and 1-bit complex product
   // ------------------------------------------------------------
   always_comb begin
      pair  = corr_pair(LANE * `CORR_TRATE + int'(rd_adr_i));
      ant_a = pair[2*CORR_PW-1:CORR_PW];
      ant_b = pair[CORR_PW-1:0];
      ra    = re_i[ant_a];
      ia    = im_i[ant_a];
      rb    = re_i[ant_b];
      ib    = im_i[ant_b];
      // a * conj(b)
      prod_re = pm1(ra ~^ rb) + pm1(ia ~^ ib); // ra*rb + ia*ib
      prod_im = pm1(ia ~^ rb) - pm1(ra ~^ ib); // ia*rb - ra*ib
   end

   // ------------------------------------------------------------
   // Stage 1, read accumulator
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      acc_q  <= acc_mem[rd_adr_i];
      p_re_q <= prod_re;
      p_im_q <= prod_im;
      clr_q  <= clear_i;
   end

   // ------------------------------------------------------------
   // Stage 2, add
   // ------------------------------------------------------------
   always_comb begin
      base = clr_q ? '0 : acc_q; // fresh bank starts at zero
   end

   always_ff @(posedge clk_x) begin
      sum_q.re <= base.re + {{(`CORR_ACCUM-3){p_re_q[2]}}, p_re_q};
      sum_q.im <= base.im + {{(`CORR_ACCUM-3){p_im_q[2]}}, p_im_q};
   end

   // Valid strobes follow en through both stages
   always_ff @(posedge clk_x) begin
      if (rst) begin
         v1_q <= 1'b0;
         v2_q <= 1'b0;
      end else begin
         v1_q <= en_i;
         v2_q <= v1_q;
      end
   end

   // ------------------------------------------------------------
   // Write back, wr_adr_i is the slot read two cycles ago
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (v2_q)
         acc_mem[wr_adr_i] <= sum_q;
   end

   assign vld_o = v2_q;
   assign vis_o = sum_q; // also goes to the visibility buffer

endmodule

/* hw/rmw_address_unit.sv */
`include "corr_params.svh"

module rmw_address_unit (
   input  logic                   clk_x,
   input  logic                   rst,
   input  logic                   ce_i,      // slot counter runs while high
   output logic [`CORR_TBITS-1:0] rd_adr_o,
   output logic [`CORR_TBITS-1:0] wr_adr_o,  // rd_adr_o two cycles late
   output logic                   rd_wrap_o,
   output logic                   wr_wrap_o
);

   localparam logic [`CORR_TBITS-1:0] LAST = `CORR_TBITS'(`CORR_TRATE - 1);

   logic [`CORR_TBITS-1:0] cnt_q;
   logic [`CORR_TBITS-1:0] adr_d1, adr_d2; // write-side delay line
   logic                   ce_d1, ce_d2;

   // ------------------------------------------------------------
   // Read side
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst || !ce_i) begin
         cnt_q <= '0; // parked at slot 0
      end else if (cnt_q == LAST) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign rd_adr_o  = cnt_q;
   assign rd_wrap_o = ce_i && (cnt_q == LAST); // last read of a pass

   // ------------------------------------------------------------
   // Write side tracks the lane's two-stage pipeline
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ce_d1 <= 1'b0;
         ce_d2 <= 1'b0;
      end else begin
         ce_d1 <= ce_i;
         ce_d2 <= ce_d1;
      end
   end

   // Slot address delayed to the write stage
   always_ff @(posedge clk_x) begin
      adr_d1 <= cnt_q;
      adr_d2 <= adr_d1;
   end

   assign wr_adr_o  = adr_d2;
   assign wr_wrap_o = ce_d2 && (adr_d2 == LAST); // last write of a pass

endmodule

/* hw/vis_buffer.sv */
`include "corr_params.svh"

module vis_buffer
   import corr_pkg::*;
(
   input  logic                                 clk_x,
   input  logic                                 we_i,
   input  logic [`CORR_BBITS+`CORR_TBITS-1:0]   wr_adr_i, // {bank, slot}
   input  vis_t [`CORR_LANES-1:0]               vis_i,
   input  bus_req_t                             req_i,
   output logic [`CORR_ACCUM-1:0]               dat_o
);

   localparam int ROWS = 2 ** (`CORR_BBITS + `CORR_TBITS);

   // One row holds all lanes for a {bank, slot}
   vis_t [`CORR_LANES-1:0] mem [ROWS];

   vis_t [`CORR_LANES-1:0] row_q;
   logic [1:0]             lane_q; // lane field of the address
   logic                   part_q; // 1 selects Im
   vis_t                   word;

   // ------------------------------------------------------------
   // Write port, from the lanes
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (we_i)
         mem[wr_adr_i] <= vis_i;
   end

   // ------------------------------------------------------------
   // Read port, row then word
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (req_i.cyc && req_i.stb) begin
         row_q  <= mem[req_i.adr[`CORR_ABITS-1:3]];
         lane_q <= req_i.adr[2:1];
         part_q <= req_i.adr[0];
      end
   end

   always_comb begin
      word = row_q[lane_q];
   end

   // Output register lines up with ack
   always_ff @(posedge clk_x) begin
      dat_o <= part_q ? word.im : word.re;
   end

endmodule

/* include/corr_params.svh */
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

// ------------------------------------------------------------
// Correlator array sizes
// ------------------------------------------------------------

// Antennas, one sign bit each for Re and Im
`define CORR_NANT 8

// Lanes working in parallel
`define CORR_LANES 4

// Slots per lane (time-multiplexing rate)
`define CORR_TRATE 4
`define CORR_TBITS 2 // log2 of the rate

// Visibility buffer banks
`define CORR_BBITS 3 // 8 banks

// ------------------------------------------------------------
// Datapath and bus widths
// ------------------------------------------------------------

// Signed accumulator, wraps modulo 2^16
`define CORR_ACCUM 16

// Bus address is {bank, slot, lane, re/im}
`define CORR_ABITS (`CORR_BBITS + `CORR_TBITS + 3)

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the correlator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f build.f --top-module correlator_block_tb -Mdir obj_dir; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vcorrelator_block_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1

/* tb/correlator_block_tb.sv */
`include "corr_params.svh"

module correlator_block_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACK_TIMEOUT  = 16; // cycles
   localparam int BANK_TIMEOUT = 64;
   localparam int NANT         = `CORR_NANT;

   logic                   clk_x = 1'b0;
   logic                   rst;
   logic                   cyc_i, stb_i;
   logic [`CORR_ABITS-1:0] adr_i;
   logic                   ack_o;
   logic [`CORR_ACCUM-1:0] dat_o;
   logic                   sw_i, en_i;
   logic [`CORR_NANT-1:0]  re_i, im_i;
   logic [`CORR_BBITS-1:0] bank_o;

   // Sent samples tagged with their bank
   logic [`CORR_NANT-1:0]  q_re[$];
   logic [`CORR_NANT-1:0]  q_im[$];
   int                     q_bank[$];
   logic [`CORR_ABITS-1:0] pend_adr[$]; // reads waiting for ack

   int err_cnt  = 0;
   int chk_cnt  = 0;
   int test_no  = 0;
   int cur_bank = 0; // bank the DUT should be filling

   correlator_block correlator_block_i (
      .clk_x  (clk_x),
      .rst    (rst),
      .cyc_i  (cyc_i),
      .stb_i  (stb_i),
      .adr_i  (adr_i),
      .ack_o  (ack_o),
      .dat_o  (dat_o),
      .sw_i   (sw_i),
      .en_i   (en_i),
      .re_i   (re_i),
      .im_i   (im_i),
      .bank_o (bank_o)
   );

   always #2 clk_x = ~clk_x; // 4 ns period

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   function automatic int bit_value(input logic x);
      return x ? 1 : -1;
   endfunction

   // Lexicographic pair list where row a has NANT-1-a entries
   function automatic void pair_of(input int idx, output int a, output int b);
      int rest;
      rest = idx;
      a = 0;
      while (rest >= NANT - 1 - a) begin
         rest = rest - (NANT - 1 - a);
         a++;
      end
      b = a + 1 + rest;
   endfunction

   // Sum of a * conj(b) over one bank wrapped to 16 bits
   function automatic logic [15:0] ref_word(input int bank, input int pidx, input logic part);
      int                 a, b;
      int                 ra, ia, rb, ib;
      logic signed [15:0] acc;
      acc = '0;
      pair_of(pidx, a, b);
      for (int i = 0; i < q_re.size(); i++) begin
         if (q_bank[i] == bank) begin
            ra = bit_value(q_re[i][a[2:0]]);
            ia = bit_value(q_im[i][a[2:0]]);
            rb = bit_value(q_re[i][b[2:0]]);
            ib = bit_value(q_im[i][b[2:0]]);
            if (part)
               acc = acc + 16'(ia * rb - ra * ib); // Im
            else
               acc = acc + 16'(ra * rb + ia * ib); // Re
         end
      end
      return acc;
   endfunction

   // ------------------------------------------------------------
   // Checks and reporting
   // ------------------------------------------------------------
   task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
      chk_cnt++;
      if (got !== want) begin
         err_cnt++;
         $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
      end
   endtask

   task automatic give_up(input string why);
      $display("Run stopped at %0t ns: %s", $time, why);
      $display("Checks failed");
      $finish;
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_no++;
      if (err_cnt == errs_before)
         $display("test %0d %s: ok", test_no, name);
      else
         $display("test %0d %s: %0d errors", test_no, name, err_cnt - errs_before);
   endtask

   // Every read is matched against the model when ack_o is seen
   always @(negedge clk_x) begin : compare_reads
      logic [`CORR_ABITS-1:0] adr;
      logic [`CORR_ACCUM-1:0] want;
      if (ack_o === 1'b1) begin
         if (pend_adr.size() == 0) begin
            err_cnt++;
            $display("Unexpected ack_o at %0t ns with no read outstanding", $time);
         end else begin
            adr  = pend_adr.pop_front();
            // {bank[7:5], slot[4:3], lane[2:1], im[0]}
            want = ref_word(int'(adr[7:5]), int'(adr[2:1]) * 4 + int'(adr[4:3]), adr[0]);
            check_eq(32'(dat_o), 32'(want),
                     $sformatf("read bank %0d slot %0d lane %0d part %0d",
                               adr[7:5], adr[4:3], adr[2:1], adr[0]));
         end
      end
   end

   // ------------------------------------------------------------
   // Stimulus helpers that drive 1 ns after the edge
   // ------------------------------------------------------------
   task automatic step();
      @(posedge clk_x);
      #1;
   endtask

   // One sample held for its four slots
   task automatic send_sample(input logic [7:0] re, input logic [7:0] im, input logic sw);
      en_i = 1'b1;
      re_i = re;
      im_i = im;
      sw_i = sw; // switch rides with the last sample of a bank
      q_re.push_back(re);
      q_im.push_back(im);
      q_bank.push_back(cur_bank);
      step();
      sw_i = 1'b0;
      repeat (3) step();
   endtask

   task automatic pause(input int n);
      en_i = 1'b0;
      repeat (n) begin
         re_i = 8'($urandom); // never captured
         im_i = 8'($urandom);
         step();
      end
   endtask

   task automatic wait_bank(input int want);
      int n;
      n = 0;
      while (bank_o !== 3'(want) && n < BANK_TIMEOUT) begin
         step();
         n++;
      end
      if (bank_o !== 3'(want))
         give_up($sformatf("bank_o never reached %0d", want));
   endtask

   task automatic switch_paused();
      sw_i = 1'b1;
      step();
      sw_i = 1'b0;
      cur_bank++;
      wait_bank(cur_bank);
   endtask

   task automatic bus_read(input logic [`CORR_ABITS-1:0] adr, input int hold);
      int lat;
      int acks;
      pend_adr.push_back(adr);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = adr;
      lat   = 0;
      acks  = 0;
      while (!ack_o && lat < ACK_TIMEOUT) begin
         step();
         lat++;
         if (lat == hold) begin
            cyc_i = 1'b0;
            stb_i = 1'b0;
         end
      end
      if (!ack_o) begin
         give_up("no ack_o came back for a bus read");
      end else begin
         check_eq(32'(lat), 32'd2, "ack_o latency in cycles");
         // Held strobe must not start a second read
         repeat (3) begin
            step();
            if (ack_o)
               acks++;
         end
         check_eq(32'(acks), 32'd0, "extra ack_o cycles after a read");
      end
   endtask

   task automatic read_bank(input int b);
      for (int slot = 0; slot < `CORR_TRATE; slot++)
         for (int lane = 0; lane < `CORR_LANES; lane++)
            for (int part = 0; part < 2; part++)
               bus_read({3'(b), 2'(slot), 2'(lane), 1'(part)}, 1);
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      int          mark;
      logic [31:0] v;
      void'($urandom(32'h58d5));
      rst   = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      adr_i = '0;
      sw_i  = 1'b0;
      en_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      repeat (5) @(posedge clk_x);
      #1;
      rst = 1'b0;

      mark = err_cnt;
      check_eq(32'(bank_o), 32'd0, "bank_o after reset");
      repeat (8) begin
         check_eq(32'(ack_o), 32'd0, "ack_o with no request");
         step();
      end
      report_test("reset state", mark);

      mark = err_cnt;
      repeat (10) send_sample(8'($urandom), 8'($urandom), 1'b0);
      pause(4);
      switch_paused();
      read_bank(0);
      report_test("first bank readback", mark);

      // Single and held strobes on random words of bank 0
      mark = err_cnt;
      for (int i = 0; i < 8; i++)
         bus_read({3'd0, 5'($urandom)}, (i % 2) + 1);
      report_test("ack timing", mark);

      mark = err_cnt;
      repeat (6) send_sample(8'($urandom), 8'($urandom), 1'b0);
      pause(7); // sums hold while nothing is captured
      repeat (5) send_sample(8'($urandom), 8'($urandom), 1'b0);
      pause(4);
      switch_paused();
      read_bank(1);
      report_test("enable pause", mark);

      // Back to back banks of 3, 7 and 2 samples with the switch on the last one
      mark = err_cnt;
      for (int k = 0; k < 3; k++) send_sample(8'($urandom), 8'($urandom), k == 2);
      cur_bank++;
      for (int k = 0; k < 7; k++) send_sample(8'($urandom), 8'($urandom), k == 6);
      cur_bank++;
      for (int k = 0; k < 2; k++) send_sample(8'($urandom), 8'($urandom), k == 1);
      cur_bank++;
      pause(6);
      wait_bank(cur_bank);
      read_bank(2);
      read_bank(3);
      read_bank(4);
      report_test("multiple banks", mark);

      // Re gains 2 per sample so 16400 samples pass 2^15
      mark = err_cnt;
      repeat (16400) begin
         v = $urandom;
         send_sample({8{v[0]}}, {8{v[1]}}, 1'b0);
      end
      pause(4);
      switch_paused();
      read_bank(5);
      report_test("accumulator wrap", mark);

      check_eq(32'(pend_adr.size()), 32'd0, "reads left without ack");
      $display("%0d tests, %0d checks, %0d errors", test_no, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
